// ==== source/busPkg.sv ====
`default_nettype none

package busPkg;

    // system size
    localparam int NUM_CORES = 2;
    localparam int WORD_BITS = 32;

    // data words and byte addresses share one width
    typedef logic [WORD_BITS-1:0] word_t;

    // one bit is enough for two cores
    typedef logic [$clog2(NUM_CORES)-1:0] coreId_t;

    // ram status as reported by the memory
    // ACCESS marks the cycle in which the current word completes
    typedef enum logic [1:0] {
        FREE,
        BUSY,
        ACCESS,
        ERROR
    } ramState_t;

endpackage

`default_nettype wire

// ==== source/coherencePkg.sv ====
`default_nettype none

package coherencePkg;

    // block geometry
    localparam int BLOCK_WORDS = 2;
    localparam int OFFSET_BIT  = 2;
    // xor mask that turns a word address into its block companion
    localparam int OFFSET_MASK = (BLOCK_WORDS - 1) << OFFSET_BIT;

    // what the granted port asked for
    typedef enum logic [1:0] {
        READ_MISS,
        WRITE_MISS,
        EVICT,
        INSTR_FETCH
    } reqKind_t;

    // sequencer phases
    typedef enum logic [3:0] {
        IDLE,
        SNOOP,
        CHECK,
        SNOOP_WB1,
        SNOOP_WB2,
        FILL1,
        FILL2,
        EVICT1,
        EVICT2,
        IFETCH
    } phase_t;

endpackage

`default_nettype wire

// ==== source/busCtrlIf.sv ====
`default_nettype none

interface busCtrlIf;

    import busPkg::*;
    import coherencePkg::*;

    // grant held by the arbiter for a whole transaction
    coreId_t  granted;
    reqKind_t kind;
    logic     start;

    // sequencer status
    phase_t phase;
    logic   snoopDirty;
    logic   wordDone;
    // pulse on the last word of a transaction frees the arbiter
    logic   grantRelease;

    modport arbiter (
        output granted,
        output kind,
        output start,
        input  grantRelease
    );

    modport sequencer (
        input  granted,
        input  kind,
        input  start,
        output phase,
        output snoopDirty,
        output wordDone,
        output grantRelease
    );

    modport mux (
        input granted,
        input kind,
        input phase,
        input wordDone
    );

endinterface

`default_nettype wire

// ==== source/requestArbiter.sv ====
`default_nettype none

module requestArbiter (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic [busPkg::NUM_CORES-1:0] dREN,
    input  logic [busPkg::NUM_CORES-1:0] dWEN,
    input  logic [busPkg::NUM_CORES-1:0] iREN,
    input  logic [busPkg::NUM_CORES-1:0] cctrans,
    busCtrlIf.arbiter                    ctrl
);

    import busPkg::*;
    import coherencePkg::*;

    logic     busy;
    logic     pickValid;
    coreId_t  pickCore;
    reqKind_t pickKind;

    // data before instruction and core 0 before core 1
    // loops run lowest priority first so later hits override
    always_comb begin
        pickValid = 1'b0;
        pickCore  = '0;
        pickKind  = INSTR_FETCH;
        for (int c = NUM_CORES - 1; c >= 0; c--) begin
            if (iREN[c]) begin
                pickValid = 1'b1;
                pickCore  = coreId_t'(c);
                pickKind  = INSTR_FETCH;
            end
        end
        for (int c = NUM_CORES - 1; c >= 0; c--) begin
            if (dWEN[c]) begin
                pickValid = 1'b1;
                pickCore  = coreId_t'(c);
                // cctrans on a write means a dirty block goes back
                pickKind  = cctrans[c] ? EVICT : WRITE_MISS;
            end else if (dREN[c]) begin
                pickValid = 1'b1;
                pickCore  = coreId_t'(c);
                pickKind  = READ_MISS;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy         <= 1'b0;
            ctrl.start   <= 1'b0;
            ctrl.granted <= '0;
            ctrl.kind    <= READ_MISS;
        end else begin
            ctrl.start <= 1'b0;
            if (!busy) begin
                if (pickValid) begin
                    busy         <= 1'b1;
                    ctrl.start   <= 1'b1;
                    ctrl.granted <= pickCore;
                    ctrl.kind    <= pickKind;
                end
            end else if (ctrl.grantRelease) begin
                // grant stays put until the last word is done
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/coherenceSequencer.sv ====
`default_nettype none

module coherenceSequencer (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic [busPkg::NUM_CORES-1:0] cctrans,
    input  logic [busPkg::NUM_CORES-1:0] ccwrite,
    input  busPkg::ramState_t            ramState,
    busCtrlIf.sequencer                  ctrl
);

    import busPkg::*;
    import coherencePkg::*;

    coreId_t other;
    phase_t  nextPhase;
    logic    wordPhase;
    logic    lastPhase;

    assign other = ~ctrl.granted;

    // phases that move one ram word and wait for ACCESS
    assign wordPhase = ctrl.phase inside {SNOOP_WB1, SNOOP_WB2, FILL1, FILL2,
                                          EVICT1, EVICT2, IFETCH};
    assign lastPhase = ctrl.phase inside {FILL2, EVICT2, IFETCH};

    assign ctrl.wordDone     = wordPhase && (ramState == ACCESS);
    assign ctrl.grantRelease = ctrl.wordDone && lastPhase;

    always_comb begin
        nextPhase = ctrl.phase;
        case (ctrl.phase)
            IDLE: begin
                if (ctrl.start) begin
                    case (ctrl.kind)
                        EVICT:       nextPhase = EVICT1;
                        INSTR_FETCH: nextPhase = IFETCH;
                        default:     nextPhase = SNOOP;
                    endcase
                end
            end
            SNOOP: nextPhase = CHECK;
            // modified copy elsewhere goes to ram before the fill
            CHECK: nextPhase = ctrl.snoopDirty ? SNOOP_WB1 : FILL1;
            SNOOP_WB1: begin
                if (ctrl.wordDone) begin
                    nextPhase = SNOOP_WB2;
                end
            end
            SNOOP_WB2: begin
                if (ctrl.wordDone) begin
                    nextPhase = FILL1;
                end
            end
            FILL1: begin
                if (ctrl.wordDone) begin
                    nextPhase = FILL2;
                end
            end
            EVICT1: begin
                if (ctrl.wordDone) begin
                    nextPhase = EVICT2;
                end
            end
            FILL2, EVICT2, IFETCH: begin
                if (ctrl.wordDone) begin
                    nextPhase = IDLE;
                end
            end
            default: nextPhase = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ctrl.phase      <= IDLE;
            ctrl.snoopDirty <= 1'b0;
        end else begin
            ctrl.phase <= nextPhase;
            // other cache answers during the single snoop cycle
            if (ctrl.phase == SNOOP) begin
                ctrl.snoopDirty <= cctrans[other] && ccwrite[other];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/ramPortMux.sv ====
`default_nettype none

module ramPortMux (
    input  busPkg::word_t                iaddr       [busPkg::NUM_CORES],
    input  busPkg::word_t                daddr       [busPkg::NUM_CORES],
    input  busPkg::word_t                dstore      [busPkg::NUM_CORES],
    input  logic [busPkg::NUM_CORES-1:0] dREN,
    input  logic [busPkg::NUM_CORES-1:0] dWEN,
    input  logic [busPkg::NUM_CORES-1:0] iREN,
    input  busPkg::word_t                ramload,
    output logic                         ramREN,
    output logic                         ramWEN,
    output busPkg::word_t                ramaddr,
    output busPkg::word_t                ramstore,
    output busPkg::word_t                iload       [busPkg::NUM_CORES],
    output busPkg::word_t                dload       [busPkg::NUM_CORES],
    output busPkg::word_t                ccsnoopaddr [busPkg::NUM_CORES],
    output logic [busPkg::NUM_CORES-1:0] iwait,
    output logic [busPkg::NUM_CORES-1:0] dwait,
    output logic [busPkg::NUM_CORES-1:0] ccwait,
    output logic [busPkg::NUM_CORES-1:0] ccinv,
    busCtrlIf.mux                        ctrl
);

    import busPkg::*;
    import coherencePkg::*;

    coreId_t other;
    word_t   grantAddr;
    word_t   companion;
    logic    dataWord;
    logic    instrWord;

    assign other     = ~ctrl.granted;
    assign grantAddr = daddr[ctrl.granted];
    // second word of the snooped block
    assign companion = grantAddr ^ word_t'(OFFSET_MASK);

    always_comb begin
        ramREN   = 1'b0;
        ramWEN   = 1'b0;
        ramaddr  = '0;
        ramstore = '0;
        ccwait   = '0;
        ccinv    = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            iload[c]       = '0;
            dload[c]       = '0;
            ccsnoopaddr[c] = '0;
        end
        case (ctrl.phase)
            SNOOP, CHECK, SNOOP_WB1: begin
                ccwait[other]      = 1'b1;
                ccsnoopaddr[other] = grantAddr;
                // first dirty word from the other cache
                if (ctrl.phase == SNOOP_WB1) begin
                    ramWEN   = 1'b1;
                    ramaddr  = daddr[other];
                    ramstore = dstore[other];
                end
            end
            SNOOP_WB2: begin
                ccwait[other]      = 1'b1;
                ccsnoopaddr[other] = companion;
                ccinv[other]       = 1'b1;
                ramWEN             = 1'b1;
                ramaddr            = daddr[other];
                ramstore           = dstore[other];
            end
            FILL1, FILL2: begin
                ramREN                = 1'b1;
                ramaddr               = grantAddr;
                dload[ctrl.granted]   = ramload;
                // read-exclusive drops the other copy on the last word
                if (ctrl.phase == FILL2 && ctrl.kind == WRITE_MISS) begin
                    ccinv[other] = 1'b1;
                end
            end
            EVICT1, EVICT2: begin
                ramWEN   = 1'b1;
                ramaddr  = grantAddr;
                ramstore = dstore[ctrl.granted];
            end
            IFETCH: begin
                ramREN              = 1'b1;
                ramaddr             = iaddr[ctrl.granted];
                iload[ctrl.granted] = ramload;
            end
            default: ;
        endcase
    end

    // only the port whose own word completes is let go
    assign dataWord  = ctrl.wordDone && (ctrl.phase inside {FILL1, FILL2, EVICT1, EVICT2});
    assign instrWord = ctrl.wordDone && (ctrl.phase == IFETCH);

    always_comb begin
        for (int c = 0; c < NUM_CORES; c++) begin
            dwait[c] = (dREN[c] || dWEN[c]) && !(dataWord && ctrl.granted == coreId_t'(c));
            iwait[c] = iREN[c] && !(instrWord && ctrl.granted == coreId_t'(c));
        end
    end

endmodule

`default_nettype wire

// ==== source/memoryBusController.sv ====
`default_nettype none

module memoryBusController (
    input  logic                         CLK,
    input  logic                         nRST,
    // instruction ports
    input  logic [busPkg::NUM_CORES-1:0] iREN,
    input  busPkg::word_t                iaddr       [busPkg::NUM_CORES],
    output busPkg::word_t                iload       [busPkg::NUM_CORES],
    output logic [busPkg::NUM_CORES-1:0] iwait,
    // data ports
    input  logic [busPkg::NUM_CORES-1:0] dREN,
    input  logic [busPkg::NUM_CORES-1:0] dWEN,
    input  busPkg::word_t                daddr       [busPkg::NUM_CORES],
    input  busPkg::word_t                dstore      [busPkg::NUM_CORES],
    output busPkg::word_t                dload       [busPkg::NUM_CORES],
    output logic [busPkg::NUM_CORES-1:0] dwait,
    // snoop side
    input  logic [busPkg::NUM_CORES-1:0] cctrans,
    input  logic [busPkg::NUM_CORES-1:0] ccwrite,
    output logic [busPkg::NUM_CORES-1:0] ccwait,
    output logic [busPkg::NUM_CORES-1:0] ccinv,
    output busPkg::word_t                ccsnoopaddr [busPkg::NUM_CORES],
    // single-ported ram
    output logic                         ramREN,
    output logic                         ramWEN,
    output busPkg::word_t                ramaddr,
    output busPkg::word_t                ramstore,
    input  busPkg::word_t                ramload,
    input  busPkg::ramState_t            ramState
);

    busCtrlIf ctrl ();

    requestArbiter arbiter_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .dREN    (dREN),
        .dWEN    (dWEN),
        .iREN    (iREN),
        .cctrans (cctrans),
        .ctrl    (ctrl.arbiter)
    );

    coherenceSequencer sequencer_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .cctrans  (cctrans),
        .ccwrite  (ccwrite),
        .ramState (ramState),
        .ctrl     (ctrl.sequencer)
    );

    ramPortMux mux_i (
        .iaddr       (iaddr),
        .daddr       (daddr),
        .dstore      (dstore),
        .dREN        (dREN),
        .dWEN        (dWEN),
        .iREN        (iREN),
        .ramload     (ramload),
        .ramREN      (ramREN),
        .ramWEN      (ramWEN),
        .ramaddr     (ramaddr),
        .ramstore    (ramstore),
        .iload       (iload),
        .dload       (dload),
        .ccsnoopaddr (ccsnoopaddr),
        .iwait       (iwait),
        .dwait       (dwait),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ctrl        (ctrl.mux)
    );

endmodule

`default_nettype wire

// ==== tb/ramModel.sv ====
`default_nettype none

module ramModel (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              ramREN,
    input  logic              ramWEN,
    input  busPkg::word_t     ramaddr,
    input  busPkg::word_t     ramstore,
    output busPkg::word_t     ramload,
    output busPkg::ramState_t ramState
);

    timeunit 1ns;
    timeprecision 100ps;

    import busPkg::*;

    localparam int LATENCY = 3;

    word_t store [word_t];
    int    count;
    logic  request;

    // never written words get a pattern scrambled from the full address
    function automatic word_t fillWord(input word_t addr);
        word_t x;
        x = addr ^ 32'h9e3779b9;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t peek(input word_t addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return fillWord(addr);
    endfunction

    assign request = ramREN || ramWEN;

    always_comb begin
        if (!request) begin
            ramState = FREE;
        end else if (count == LATENCY - 1) begin
            ramState = ACCESS;
        end else begin
            ramState = BUSY;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count   <= 0;
            ramload <= '0;
        end else if (!request || count == LATENCY - 1) begin
            count <= 0;
        end else begin
            count <= count + 1;
            // read data lines up for the ACCESS cycle
            if (count == LATENCY - 2) begin
                ramload <= peek(ramaddr);
            end
        end
    end

    always @(posedge CLK) begin
        if (ramWEN && ramState == ACCESS) begin
            store[ramaddr] = ramstore;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tbMemoryBus.sv ====
`default_nettype none

module tbMemoryBus;

    timeunit 1ns;
    timeprecision 100ps;

    import busPkg::*;
    import coherencePkg::*;

    localparam int TIMEOUT = 200;

    logic                 CLK;
    logic                 nRST;
    logic [NUM_CORES-1:0] iREN;
    logic [NUM_CORES-1:0] iwait;
    logic [NUM_CORES-1:0] dREN;
    logic [NUM_CORES-1:0] dWEN;
    logic [NUM_CORES-1:0] dwait;
    logic [NUM_CORES-1:0] cctrans;
    logic [NUM_CORES-1:0] ccwrite;
    logic [NUM_CORES-1:0] ccwait;
    logic [NUM_CORES-1:0] ccinv;
    word_t                iaddr       [NUM_CORES];
    word_t                iload       [NUM_CORES];
    word_t                daddr       [NUM_CORES];
    word_t                dstore      [NUM_CORES];
    word_t                dload       [NUM_CORES];
    word_t                ccsnoopaddr [NUM_CORES];
    logic                 ramREN;
    logic                 ramWEN;
    word_t                ramaddr;
    word_t                ramstore;
    word_t                ramload;
    ramState_t            ramState;

    int          errorCount;
    int          testsRun;
    int          testsFailed;
    logic [31:0] rngState;

    // bus activity seen by the monitor
    int                   cycleCount   = 0;
    int                   wenCycles    = 0;
    int                   renCycles    = 0;
    int                   ccwaitCycles = 0;
    word_t                wrAddr [$];
    word_t                wrData [$];
    logic [NUM_CORES-1:0] wrInv  [$];

    memoryBusController dut_i (.*);

    ramModel ram_i (.*);

    initial begin
        CLK = 1'b0;
        forever begin
            #5 CLK = ~CLK;
        end
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
    end

    always @(negedge CLK) begin
        if (ramWEN) begin
            wenCycles++;
        end
        if (ramREN) begin
            renCycles++;
        end
        if (ccwait != '0) begin
            ccwaitCycles++;
        end
        if (ramWEN && ramState == ACCESS) begin
            wrAddr.push_back(ramaddr);
            wrData.push_back(ramstore);
            wrInv.push_back(ccinv);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic randomWord(output word_t w);
        rngState = xorshift32(rngState);
        w = rngState;
    endtask

    // other word of the same block
    function automatic word_t companionOf(input word_t a);
        return a ^ (word_t'(1) << OFFSET_BIT);
    endfunction

    task automatic stepClock();
        @(posedge CLK);
        #1;
    endtask

    task automatic checkValue(input string testName, input string what,
                              input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("** Error %s: %s expected %h, actual %h", testName, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkTrue(input string testName, input logic cond, input string message);
        assert (cond === 1'b1) else begin
            $display("%s: %s", testName, message);
            errorCount++;
        end
    endtask

    // waits for the port's wait to drop and samples at the falling edge
    task automatic waitWord(input coreId_t core, input logic instr, input string testName,
                            output word_t data, output logic [NUM_CORES-1:0] inv,
                            output int doneCycle);
        int n;
        n = 0;
        @(negedge CLK);
        while ((instr ? iwait[core] : dwait[core]) && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        checkTrue(testName, n < TIMEOUT, "wait signal never dropped");
        data      = instr ? iload[core] : dload[core];
        inv       = ccinv;
        doneCycle = cycleCount;
        stepClock();
    endtask

    // one two-word data transaction from a core
    task automatic dataRequest(input coreId_t core, input logic write, input logic trans,
                               input word_t addr, input word_t st0, input word_t st1,
                               input string testName, output word_t ld0, output word_t ld1,
                               output logic [NUM_CORES-1:0] inv1, output int done1);
        logic [NUM_CORES-1:0] inv0;
        int                   done0;
        dREN[core]    = !write;
        dWEN[core]    = write;
        cctrans[core] = trans;
        daddr[core]   = addr;
        dstore[core]  = st0;
        waitWord(core, 1'b0, testName, ld0, inv0, done0);
        daddr[core]  = companionOf(addr);
        dstore[core] = st1;
        waitWord(core, 1'b0, testName, ld1, inv1, done1);
        dREN[core]    = 1'b0;
        dWEN[core]    = 1'b0;
        cctrans[core] = 1'b0;
    endtask

    // cache stand-in on the snooped side
    task automatic answerSnoop(input coreId_t core, input logic trans, input logic write,
                               input word_t blockAddr, input word_t wb0, input word_t wb1,
                               input string testName);
        int n;
        // line state is known before the single snoop cycle
        cctrans[core] = trans;
        ccwrite[core] = write;
        daddr[core]   = blockAddr;
        dstore[core]  = wb0;
        n = 0;
        @(negedge CLK);
        while (!ccwait[core] && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        checkTrue(testName, n < TIMEOUT, "snoop never reached the other cache");
        checkValue(testName, "ccsnoopaddr", blockAddr, ccsnoopaddr[core]);
        if (trans && write) begin
            // first write-back word leaves on its ACCESS cycle
            n = 0;
            while (!(ramWEN && ramState == ACCESS) && n < TIMEOUT) begin
                @(negedge CLK);
                n++;
            end
            checkTrue(testName, n < TIMEOUT, "first write-back word never finished");
            stepClock();
            daddr[core]  = companionOf(blockAddr);
            dstore[core] = wb1;
            @(negedge CLK);
            checkValue(testName, "companion snoop address", companionOf(blockAddr),
                       ccsnoopaddr[core]);
        end
        n = 0;
        while (ccwait[core] && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        checkTrue(testName, n < TIMEOUT, "ccwait never dropped");
        stepClock();
        cctrans[core] = 1'b0;
        ccwrite[core] = 1'b0;
    endtask

    task automatic finishTest(input string testName, input int errorsBefore);
        testsRun++;
        if (errorCount != errorsBefore) begin
            testsFailed++;
            $display("%s: FAIL", testName);
        end else begin
            $display("%s: PASS", testName);
        end
        // bus back to idle before the next test
        repeat (2) stepClock();
    endtask

    task automatic testFetch();
        string                name = "fetch";
        int                   errorsBefore;
        int                   wenBefore;
        int                   done;
        word_t                expected;
        word_t                got;
        logic [NUM_CORES-1:0] inv;
        errorsBefore = errorCount;
        wenBefore    = wenCycles;
        expected     = ram_i.peek(32'h0000_0040);
        iREN[0]  = 1'b1;
        iaddr[0] = 32'h0000_0040;
        waitWord(1'b0, 1'b1, name, got, inv, done);
        iREN[0] = 1'b0;
        checkValue(name, "iload", expected, got);
        checkTrue(name, wenCycles == wenBefore, "ramWEN rose during a fetch");
        finishTest(name, errorsBefore);
    endtask

    task automatic testCleanRead();
        string                name = "clean read miss";
        word_t                addr = 32'h0000_0100;
        int                   errorsBefore;
        int                   wenBefore;
        int                   done;
        word_t                exp0;
        word_t                exp1;
        word_t                ld0;
        word_t                ld1;
        logic [NUM_CORES-1:0] inv;
        errorsBefore = errorCount;
        wenBefore    = wenCycles;
        exp0 = ram_i.peek(addr);
        exp1 = ram_i.peek(companionOf(addr));
        fork
            answerSnoop(1'b0, 1'b0, 1'b0, addr, '0, '0, name);
            dataRequest(1'b1, 1'b0, 1'b0, addr, '0, '0, name, ld0, ld1, inv, done);
        join
        checkValue(name, "first dload", exp0, ld0);
        checkValue(name, "second dload", exp1, ld1);
        checkTrue(name, wenCycles == wenBefore, "ramWEN rose during a clean read");
        finishTest(name, errorsBefore);
    endtask

    task automatic testDirtyRead();
        string                name = "dirty read miss";
        word_t                addr = 32'h0000_0200;
        int                   errorsBefore;
        int                   wrStart;
        int                   done;
        word_t                wb0;
        word_t                wb1;
        word_t                ld0;
        word_t                ld1;
        logic [NUM_CORES-1:0] inv;
        errorsBefore = errorCount;
        wrStart      = wrAddr.size();
        randomWord(wb0);
        randomWord(wb1);
        fork
            answerSnoop(1'b1, 1'b1, 1'b1, addr, wb0, wb1, name);
            dataRequest(1'b0, 1'b0, 1'b0, addr, '0, '0, name, ld0, ld1, inv, done);
        join
        checkTrue(name, wrAddr.size() == wrStart + 2, "write-back did not make two writes");
        if (wrAddr.size() == wrStart + 2) begin
            checkValue(name, "first write address", addr, wrAddr[wrStart]);
            checkValue(name, "first write data", wb0, wrData[wrStart]);
            checkValue(name, "second write address", companionOf(addr), wrAddr[wrStart + 1]);
            checkValue(name, "second write data", wb1, wrData[wrStart + 1]);
            checkTrue(name, !wrInv[wrStart][1], "ccinv rose during the first write");
            checkTrue(name, wrInv[wrStart + 1][1], "ccinv stayed low on the second write");
        end
        checkValue(name, "first dload", wb0, ld0);
        checkValue(name, "second dload", wb1, ld1);
        finishTest(name, errorsBefore);
    endtask

    task automatic testWriteMiss();
        string                name = "write miss";
        word_t                addr = 32'h0000_0300;
        int                   errorsBefore;
        int                   wenBefore;
        int                   done;
        word_t                ld0;
        word_t                ld1;
        logic [NUM_CORES-1:0] inv;
        errorsBefore = errorCount;
        wenBefore    = wenCycles;
        fork
            answerSnoop(1'b1, 1'b1, 1'b0, addr, '0, '0, name);
            dataRequest(1'b0, 1'b1, 1'b0, addr, '0, '0, name, ld0, ld1, inv, done);
        join
        checkTrue(name, inv[1], "ccinv was low during the second fill word");
        checkTrue(name, wenCycles == wenBefore, "a RAM write happened on a write miss");
        finishTest(name, errorsBefore);
    endtask

    task automatic testEvict();
        string                name = "eviction";
        word_t                addr = 32'h0000_0400;
        int                   errorsBefore;
        int                   ccwaitBefore;
        int                   renBefore;
        int                   done;
        word_t                st0;
        word_t                st1;
        word_t                ld0;
        word_t                ld1;
        logic [NUM_CORES-1:0] inv;
        errorsBefore = errorCount;
        ccwaitBefore = ccwaitCycles;
        renBefore    = renCycles;
        randomWord(st0);
        randomWord(st1);
        dataRequest(1'b1, 1'b1, 1'b1, addr, st0, st1, name, ld0, ld1, inv, done);
        checkValue(name, "stored first word", st0, ram_i.peek(addr));
        checkValue(name, "stored second word", st1, ram_i.peek(companionOf(addr)));
        checkTrue(name, ccwaitCycles == ccwaitBefore, "ccwait rose during an eviction");
        checkTrue(name, renCycles == renBefore, "ramREN rose during an eviction");
        finishTest(name, errorsBefore);
    endtask

    task automatic testPriority();
        string                name = "priority";
        word_t                addr = 32'h0000_0500;
        int                   errorsBefore;
        int                   dataDone;
        int                   fetchDone;
        word_t                expected;
        word_t                got;
        word_t                ld0;
        word_t                ld1;
        logic [NUM_CORES-1:0] inv;
        logic [NUM_CORES-1:0] fetchInv;
        errorsBefore = errorCount;
        expected     = ram_i.peek(32'h0000_0080);
        fork
            dataRequest(1'b0, 1'b0, 1'b0, addr, '0, '0, name, ld0, ld1, inv, dataDone);
            begin
                iREN[1]  = 1'b1;
                iaddr[1] = 32'h0000_0080;
                waitWord(1'b1, 1'b1, name, got, fetchInv, fetchDone);
                iREN[1] = 1'b0;
            end
        join
        checkTrue(name, dataDone < fetchDone, "fetch finished before the data miss");
        checkValue(name, "iload", expected, got);
        finishTest(name, errorsBefore);
    endtask

    initial begin
        // every DUT input idle at time zero
        nRST    = 1'b0;
        iREN    = '0;
        dREN    = '0;
        dWEN    = '0;
        cctrans = '0;
        ccwrite = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            iaddr[c]  = '0;
            daddr[c]  = '0;
            dstore[c] = '0;
        end
        rngState    = 32'hd987ad78;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        repeat (8) @(posedge CLK);
        #1;
        nRST = 1'b1;
        stepClock();

        testFetch();
        testCleanRead();
        testDirtyRead();
        testWriteMiss();
        testEvict();
        testPriority();

        $display("tests run %0d, passed %0d, failed %0d",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/busPkg.sv
source/coherencePkg.sv
source/busCtrlIf.sv
source/requestArbiter.sv
source/coherenceSequencer.sv
source/ramPortMux.sv
source/memoryBusController.sv
tb/ramModel.sv
tb/tbMemoryBus.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbMemoryBus
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
